//--- rtl/fetch_pkg.sv
/*
 * shared definitions of the instruction fetch front end
 * widths of addresses, bus words and halfwords, the prefetch queue depth
 * and the small vector types passed between the fetch blocks
 */

`default_nettype none

package fetch_pkg;

	// width of an instruction address
	localparam int W_ADDR = 32;

	// width of one bus data word, always fetched word-aligned
	localparam int W_DATA = 32;

	// compressed instructions are built from halfwords of this width
	localparam int W_HALF = 16;

	// two entries are the minimum that keeps the bus busy while decode stalls
	localparam int QUEUE_DEPTH = 2;

	// bit 0 marks the low halfword of a word valid and bit 1 the high halfword
	typedef logic [1:0] hw_valid_t;

	// number of valid halfwords, from 0 up to 3
	typedef logic [1:0] level_t;

endpackage

`default_nettype wire

//--- rtl/fetch_data_if.sv
/*
 * fetch data path from the bus tracker
 * carries returned words with flushed returns already removed, and the
 * room signal by which the aligner takes a word directly off the bus
 */

`default_nettype none

interface fetch_data_if;

	logic [fetch_pkg::W_DATA-1:0] data;
	logic                         err;
	fetch_pkg::hw_valid_t         hw_vld;
	logic                         vld;
	// the aligner can accept the fetch word in this cycle
	logic                         room;

	modport source (output data, err, hw_vld, vld);
	modport push_side (input data, err, hw_vld, vld, room);
	modport bypass_side (input data, err, hw_vld, vld, output room);

endinterface

`default_nettype wire

//--- rtl/queue_head_if.sv
/*
 * prefetch queue head
 * presents the oldest buffered word to the aligner and returns its pop
 */

`default_nettype none

interface queue_head_if;

	logic [fetch_pkg::W_DATA-1:0] data;
	logic                         err;
	fetch_pkg::hw_valid_t         hw_vld;
	// no word is buffered, so the aligner reads the bus instead
	logic                         empty;
	logic                         pop;

	modport source (output data, err, hw_vld, empty, input pop);
	modport sink (input data, err, hw_vld, empty, output pop);

endinterface

`default_nettype wire

//--- rtl/fetch_request_gen.sv
/*
 * fetch request generator
 * drives word-aligned fetch addresses onto the instruction bus, tracks
 * fetches in flight and drops the returns of fetches older than a jump
 */

`default_nettype none

module fetch_request_gen #(
	parameter logic [fetch_pkg::W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic                         clk,
	input  logic                         rst_n,
	output logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	output logic                         mem_addr_vld,
	input  logic                         mem_addr_rdy,
	input  logic [fetch_pkg::W_DATA-1:0] mem_data,
	input  logic                         mem_data_err,
	input  logic                         mem_data_vld,
	input  logic [fetch_pkg::W_ADDR-1:0] jump_target,
	input  logic                         jump_target_vld,
	output logic                         jump_target_rdy,
	output logic                         jump_now,
	input  logic                         queue_full,
	input  logic                         queue_almost_full,
	fetch_data_if.source                 fetch_data
);

	// fetch_addr runs ahead of the program counter in whole words
	logic [fetch_pkg::W_ADDR-1:0] fetch_addr;
	logic [fetch_pkg::W_ADDR-1:0] jump_word;
	logic                         mem_addr_hold;
	logic                         reset_holdoff;
	logic [1:0]                   pending_fetches;
	logic [1:0]                   flush_pending;
	fetch_pkg::hw_valid_t         aph_hwvld;
	fetch_pkg::hw_valid_t         dph_hwvld;
	logic                         addr_vld_raw;
	logic                         fetch_stall;
	logic                         addr_accept;
	logic                         data_live;

	// ----------------------------------------------------------
	// address phase

	assign jump_word = {jump_target[fetch_pkg::W_ADDR-1:2], 2'b00};

	// a held address has priority, then a jump, then the sequential fetch
	always_comb begin
		mem_addr = fetch_addr;
		addr_vld_raw = 1'b1;
		if (mem_addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			mem_addr = jump_word;
			// the jump fetch waits while two older fetches are still in flight
			addr_vld_raw = !pending_fetches[1];
		end else if (fetch_stall) begin
			addr_vld_raw = 1'b0;
		end
	end

	// nothing is requested in the first cycle out of reset
	assign mem_addr_vld = addr_vld_raw && !reset_holdoff;
	assign addr_accept = mem_addr_vld && mem_addr_rdy;

	assign jump_target_rdy = !mem_addr_hold && !reset_holdoff;
	assign jump_now = jump_target_vld && jump_target_rdy;

	// only registered counts are used here, so the bus ready never reaches
	// the address phase through this term
	assign fetch_stall = queue_full
		|| (queue_almost_full && pending_fetches != 2'd0)
		|| pending_fetches[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= RESET_VECTOR;
		end else if (jump_now) begin
			// step past the target word if it went out in this same cycle
			fetch_addr <= jump_word
				+ {{(fetch_pkg::W_ADDR-3){1'b0}}, addr_accept, 2'b00};
		end else if (addr_accept) begin
			fetch_addr <= fetch_addr + fetch_pkg::W_ADDR'(4);
		end
	end

	// ----------------------------------------------------------
	// bus tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			mem_addr_hold <= 1'b0;
			pending_fetches <= 2'd0;
			flush_pending <= 2'd0;
		end else begin
			reset_holdoff <= 1'b0;
			mem_addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending_fetches <= pending_fetches + {1'b0, addr_accept} - {1'b0, mem_data_vld};
			if (jump_now) begin
				// every fetch still in flight after this cycle belongs to the old path
				flush_pending <= pending_fetches - {1'b0, mem_data_vld};
			end else if (flush_pending != 2'd0 && mem_data_vld) begin
				flush_pending <= flush_pending - 2'd1;
			end
		end
	end

	// ----------------------------------------------------------
	// halfword valid marking

	assign data_live = mem_data_vld && flush_pending == 2'd0;

	// a jump to an odd halfword invalidates the low half of its first word
	// and the marking stays with that word until it comes back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_hwvld <= 2'b11;
			dph_hwvld <= 2'b11;
		end else if (jump_now) begin
			if (addr_accept) begin
				aph_hwvld <= 2'b11;
				dph_hwvld <= {1'b1, !jump_target[1]};
			end else begin
				aph_hwvld <= {1'b1, !jump_target[1]};
				dph_hwvld <= 2'b11;
			end
		end else begin
			if (data_live) begin
				dph_hwvld <= 2'b11;
			end
			if (addr_accept && !(&aph_hwvld)) begin
				dph_hwvld <= aph_hwvld;
				aph_hwvld <= 2'b11;
			end
		end
	end

	assign fetch_data.data = mem_data;
	assign fetch_data.err = mem_data_err;
	assign fetch_data.hw_vld = dph_hwvld;
	assign fetch_data.vld = data_live;

endmodule

`default_nettype wire

//--- rtl/prefetch_queue.sv
/*
 * prefetch queue
 * compacting shift queue of fetched words with their error flags and
 * halfword valids, filled from entry 0 upward and popped from entry 0
 */

`default_nettype none

module prefetch_queue (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            jump_now,
	output logic            full,
	output logic            almost_full,
	fetch_data_if.push_side fetch_data,
	queue_head_if.source    queue_head
);

	localparam int DEPTH = fetch_pkg::QUEUE_DEPTH;

	logic [fetch_pkg::W_DATA-1:0] q_data      [DEPTH];
	logic                         q_err       [DEPTH];
	fetch_pkg::hw_valid_t         q_hwvld     [DEPTH];
	logic                         q_valid     [DEPTH];
	logic                         valid_below [DEPTH];
	fetch_pkg::hw_valid_t         hwvld_above [DEPTH];
	logic                         valid_above [DEPTH];
	logic [fetch_pkg::W_DATA-1:0] src_data    [DEPTH];
	logic                         src_err     [DEPTH];
	logic                         push;
	logic                         pop;

	// an entry loads from the one above it when that one is valid
	// and from the bus otherwise, and the top entry always loads from the bus
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			q_valid[i] = |q_hwvld[i];
		end
		valid_below[0] = 1'b1;
		for (int i = 1; i < DEPTH; i++) begin
			valid_below[i] = q_valid[i-1];
		end
		for (int i = 0; i < DEPTH - 1; i++) begin
			hwvld_above[i] = q_hwvld[i+1];
			valid_above[i] = q_valid[i+1];
			src_data[i] = q_valid[i+1] ? q_data[i+1] : fetch_data.data;
			src_err[i] = q_valid[i+1] ? q_err[i+1] : fetch_data.err;
		end
		hwvld_above[DEPTH-1] = 2'b00;
		valid_above[DEPTH-1] = 1'b0;
		src_data[DEPTH-1] = fetch_data.data;
		src_err[DEPTH-1] = fetch_data.err;
	end

	// a word the aligner takes straight off the bus is not written here
	assign push = fetch_data.vld && !(fetch_data.room && !q_valid[0]);
	assign pop = queue_head.pop;

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (pop || (push && !q_valid[i])) begin
				q_data[i] <= src_data[i];
				q_err[i] <= src_err[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				q_hwvld[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (jump_now) begin
					q_hwvld[i] <= 2'b00;
				end else if (pop && valid_above[i]) begin
					q_hwvld[i] <= hwvld_above[i];
				end else if (pop && q_valid[i]) begin
					// the top valid entry shifts down and the new word lands in its place
					q_hwvld[i] <= push ? fetch_data.hw_vld : 2'b00;
				end else if (q_valid[i]) begin
					q_hwvld[i] <= q_hwvld[i];
				end else if (push && !pop && valid_below[i]) begin
					q_hwvld[i] <= fetch_data.hw_vld;
				end else begin
					q_hwvld[i] <= 2'b00;
				end
			end
		end
	end

	assign full = q_valid[DEPTH-1];
	assign almost_full = q_valid[DEPTH-2];

	assign queue_head.data = q_data[0];
	assign queue_head.err = q_err[0];
	assign queue_head.hw_vld = q_hwvld[0];
	assign queue_head.empty = !q_valid[0];

endmodule

`default_nettype wire

//--- rtl/instr_aligner.sv
/*
 * instruction aligner
 * assembles halfwords from the queue or the bus into the current
 * instruction register, with a spare halfword and per-halfword bus errors
 */

`default_nettype none

module instr_aligner (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        jump_now,
	input  fetch_pkg::level_t           cir_use,
	output logic [2*fetch_pkg::W_HALF-1:0] cir,
	output fetch_pkg::level_t           cir_vld,
	output logic [1:0]                  cir_err,
	fetch_data_if.bypass_side           fetch_data,
	queue_head_if.sink                  queue_head
);

	localparam int H = fetch_pkg::W_HALF;

	logic [fetch_pkg::W_DATA-1:0] fetch_word;
	fetch_pkg::hw_valid_t         fetch_hwvld;
	logic                         fetch_err;
	logic                         fetch_vld;
	logic [2*H-1:0]               fetch_aligned;
	logic [H-1:0]                 hwbuf;
	fetch_pkg::level_t            level;
	fetch_pkg::level_t            level_no_fetch;
	fetch_pkg::level_t            fill;
	fetch_pkg::level_t            level_next;
	logic [3*H-1:0]               held_shifted;
	logic [3*H-1:0]               held_next;
	logic [2:0]                   err_held;
	logic [2:0]                   err_shifted;
	logic [2:0]                   err_next;
	logic                         room;

	// ----------------------------------------------------------
	// fetch word selection

	// the queue head is older than anything on the bus, so it goes first
	assign fetch_word = queue_head.empty ? fetch_data.data : queue_head.data;
	assign fetch_hwvld = queue_head.empty ? fetch_data.hw_vld : queue_head.hw_vld;
	assign fetch_err = queue_head.empty ? fetch_data.err : queue_head.err;
	assign fetch_vld = !queue_head.empty || fetch_data.vld;

	// when only the high half is valid it moves into the low position
	assign fetch_aligned = {
		fetch_word[H +: H],
		fetch_hwvld[0] ? fetch_word[0 +: H] : fetch_word[H +: H]
	};

	// ----------------------------------------------------------
	// shift and overlay

	// whatever decode consumed is shifted out and the spare halfword follows
	// positions above the new level are don't care
	always_comb begin
		case (cir_use)
			2'd2: begin
				held_shifted = {hwbuf, cir[H +: H], hwbuf};
				err_shifted = err_held >> 2;
			end
			2'd1: begin
				held_shifted = {hwbuf, hwbuf, cir[H +: H]};
				err_shifted = err_held >> 1;
			end
			default: begin
				held_shifted = {hwbuf, cir};
				err_shifted = err_held;
			end
		endcase
	end

	assign level_no_fetch = level - cir_use;

	// a full word needs two free halfwords and a half word needs one
	assign room = level_no_fetch <= (&fetch_hwvld ? 2'd1 : 2'd2);

	always_comb begin
		if (!room) begin
			held_next = held_shifted;
			err_next = err_shifted;
		end else if (level_no_fetch == 2'd2) begin
			held_next = {fetch_aligned[0 +: H], held_shifted[0 +: 2*H]};
			err_next = {fetch_err, err_shifted[1:0]};
		end else if (level_no_fetch == 2'd1) begin
			held_next = {fetch_aligned, held_shifted[0 +: H]};
			err_next = {{2{fetch_err}}, err_shifted[0]};
		end else begin
			held_next = {held_shifted[2*H +: H], fetch_aligned};
			err_next = {err_shifted[2], {2{fetch_err}}};
		end
	end

	assign fill = (room && fetch_vld) ? (&fetch_hwvld ? 2'd2 : 2'd1) : 2'd0;
	assign level_next = jump_now ? 2'd0 : level_no_fetch + fill;

	assign fetch_data.room = room;
	assign queue_head.pop = room && !queue_head.empty;

	// ----------------------------------------------------------
	// registers

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= held_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= 2'd0;
			cir_vld <= 2'd0;
			err_held <= 3'b000;
		end else begin
			level <= level_next;
			// decode never sees more than the two halfwords of cir
			cir_vld <= (level_next == 2'd3) ? 2'd2 : level_next;
			err_held <= err_next;
		end
	end

	assign cir_err = err_held[1:0];

endmodule

`default_nettype wire

//--- rtl/fetch_frontend.sv
/*
 * instruction fetch front end
 * joins fetch request generation, the prefetch queue and the aligner
 */

`default_nettype none

module fetch_frontend #(
	parameter logic [fetch_pkg::W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic                         clk,
	input  logic                         rst_n,

	// fetch bus with a held address handshake and unstalled data
	output logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	output logic                         mem_addr_vld,
	input  logic                         mem_addr_rdy,
	input  logic [fetch_pkg::W_DATA-1:0] mem_data,
	input  logic                         mem_data_err,
	input  logic                         mem_data_vld,

	// jump requests from the core
	input  logic [fetch_pkg::W_ADDR-1:0] jump_target,
	input  logic                         jump_target_vld,
	output logic                         jump_target_rdy,

	// decode side
	output logic [fetch_pkg::W_DATA-1:0] cir,
	output fetch_pkg::level_t            cir_vld,
	output logic [1:0]                   cir_err,
	input  fetch_pkg::level_t            cir_use
);

	logic queue_full;
	logic queue_almost_full;
	logic jump_now;

	fetch_data_if fetch_data ();
	queue_head_if queue_head ();

	fetch_request_gen #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_fetch_request_gen (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.mem_data          (mem_data),
		.mem_data_err      (mem_data_err),
		.mem_data_vld      (mem_data_vld),
		.jump_target       (jump_target),
		.jump_target_vld   (jump_target_vld),
		.jump_target_rdy   (jump_target_rdy),
		.jump_now          (jump_now),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full),
		.fetch_data        (fetch_data)
	);

	prefetch_queue u_prefetch_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.jump_now    (jump_now),
		.full        (queue_full),
		.almost_full (queue_almost_full),
		.fetch_data  (fetch_data),
		.queue_head  (queue_head)
	);

	instr_aligner u_instr_aligner (
		.clk        (clk),
		.rst_n      (rst_n),
		.jump_now   (jump_now),
		.cir_use    (cir_use),
		.cir        (cir),
		.cir_vld    (cir_vld),
		.cir_err    (cir_err),
		.fetch_data (fetch_data),
		.queue_head (queue_head)
	);

endmodule

`default_nettype wire

//--- verification/tb_fetch_frontend.sv
/*
 * testbench of the instruction fetch front end
 * a bus model with random stalls and latency serves a hashed memory, and a
 * halfword address model checks every instruction that decode consumes
 */

`default_nettype none

module tb_fetch_frontend;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
	localparam logic [31:0] SEED = 32'd88374;
	// the one word that answers with a bus error
	localparam logic [31:0] ERR_WORD = 32'h0000_0148;
	localparam int N_INSTR = 2000;
	// a consumed instruction takes a few cycles at most, so twenty is generous
	localparam int TIMEOUT_CYCLES = N_INSTR * 20;

	logic                 clk;
	logic                 rst_n;
	logic [31:0]          mem_addr;
	logic                 mem_addr_vld;
	logic                 mem_addr_rdy;
	logic [31:0]          mem_data;
	logic                 mem_data_err;
	logic                 mem_data_vld;
	logic [31:0]          jump_target;
	logic                 jump_target_vld;
	logic                 jump_target_rdy;
	logic [31:0]          cir;
	fetch_pkg::level_t    cir_vld;
	logic [1:0]           cir_err;
	fetch_pkg::level_t    cir_use;

	// bus model state, one entry per accepted fetch
	logic [31:0]          bus_addr_q [$];
	int                   bus_ready_q [$];

	logic [31:0]          rng_state;
	logic [31:0]          exp_addr;
	logic [31:0]          held_addr;
	logic                 addr_held;
	logic                 first_accept_seen;
	logic                 jump_taken;
	int                   cyc;
	int                   consumed;
	int                   jump_count;
	int                   mismatch_count;
	int                   bus_error_count;

	fetch_frontend #(
		.RESET_VECTOR (RESET_VECTOR)
	) dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_err         (cir_err),
		.cir_use         (cir_use)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------------------------
	// random numbers and memory contents

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// every word is a hash of its whole address, so no two words alias
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return xorshift32(xorshift32(addr ^ SEED));
	endfunction

	function automatic logic [15:0] mem_half(input logic [31:0] addr);
		logic [31:0] word;
		word = mem_word({addr[31:2], 2'b00});
		return addr[1] ? word[31:16] : word[15:0];
	endfunction

	function automatic logic in_error_word(input logic [31:0] addr);
		return addr[31:2] == ERR_WORD[31:2];
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	// ----------------------------------------------------------
	// stimulus, applied shortly after the rising edge

	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] head_addr;
		r = next_random();
		mem_addr_rdy = r[1:0] != 2'b00;
		// data comes back in order, one word per cycle, once its latency ran out
		if (bus_addr_q.size() != 0 && bus_ready_q[0] <= cyc) begin
			head_addr = bus_addr_q.pop_front();
			void'(bus_ready_q.pop_front());
			mem_data_vld = 1'b1;
			mem_data = mem_word(head_addr);
			mem_data_err = in_error_word(head_addr);
		end else begin
			mem_data_vld = 1'b0;
			mem_data = 32'h0;
			mem_data_err = 1'b0;
		end
		// a requested jump stays up until the front end takes it
		r = next_random();
		if (jump_taken) begin
			jump_target_vld = 1'b0;
			jump_taken = 1'b0;
		end else if (!jump_target_vld && first_accept_seen && r[5:0] == 6'd0) begin
			jump_target = RESET_VECTOR + {22'd0, r[17:9], 1'b0};
			jump_target_vld = 1'b1;
		end
		// decode takes one whole instruction or stalls
		r = next_random();
		if (r[1:0] == 2'b00) begin
			cir_use = 2'd0;
		end else if (cir_vld != 2'd0 && cir[1:0] != 2'b11) begin
			cir_use = 2'd1;
		end else if (cir_vld == 2'd2) begin
			cir_use = 2'd2;
		end else begin
			cir_use = 2'd0;
		end
	endtask

	// ----------------------------------------------------------
	// observation at the falling edge where everything has settled

	task automatic sample_outputs();
		logic [31:0] r;
		if (addr_held) begin
			check_value(mem_addr_vld, 1'b1, "mem_addr_vld of a pending request");
			check_value(mem_addr, held_addr, "mem_addr of a pending request");
		end
		addr_held = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
		if (mem_addr_vld && mem_addr_rdy) begin
			if (!first_accept_seen) begin
				check_value(mem_addr, RESET_VECTOR, "first fetch address");
			end
			first_accept_seen = 1'b1;
			r = next_random();
			bus_addr_q.push_back(mem_addr);
			bus_ready_q.push_back(cyc + 1 + int'(r[0]));
			if (bus_addr_q.size() > 2) begin
				bus_error_count++;
				$display("bus rule broken at %0t ns: more than two fetches outstanding",
					$time);
			end
		end
		// consumption refers to cir before any jump of this cycle
		if (cir_use != 2'd0) begin
			check_value({16'h0, cir[15:0]}, {16'h0, mem_half(exp_addr)},
				$sformatf("halfword at %h", exp_addr));
			check_value(cir_err[0], in_error_word(exp_addr),
				$sformatf("error flag of halfword at %h", exp_addr));
			if (cir_use == 2'd2) begin
				check_value({16'h0, cir[31:16]}, {16'h0, mem_half(exp_addr + 32'd2)},
					$sformatf("halfword at %h", exp_addr + 32'd2));
				check_value(cir_err[1], in_error_word(exp_addr + 32'd2),
					$sformatf("error flag of halfword at %h", exp_addr + 32'd2));
			end
			exp_addr = exp_addr + {29'd0, cir_use, 1'b0};
			consumed++;
		end
		if (jump_target_vld && jump_target_rdy) begin
			exp_addr = jump_target;
			jump_taken = 1'b1;
			jump_count++;
		end
	endtask

	// ----------------------------------------------------------
	// run control

	initial begin
		rst_n = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_data = 32'h0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		jump_target = 32'h0;
		jump_target_vld = 1'b0;
		cir_use = 2'd0;
		rng_state = SEED;
		exp_addr = RESET_VECTOR;
		held_addr = 32'h0;
		addr_held = 1'b0;
		first_accept_seen = 1'b0;
		jump_taken = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// the reset holdoff cycle shows nothing on any handshake
		@(negedge clk);
		check_value(mem_addr_vld, 1'b0, "mem_addr_vld in the first cycle after reset");
		check_value(jump_target_rdy, 1'b0, "jump_target_rdy in the first cycle after reset");
		check_value(cir_vld, 2'd0, "cir_vld in the first cycle after reset");
		check_value(cir_err, 2'b00, "cir_err in the first cycle after reset");
		while (consumed < N_INSTR) begin
			@(posedge clk);
			#1;
			cyc++;
			drive_inputs();
			@(negedge clk);
			sample_outputs();
		end
		$display("%0d instructions, %0d jumps in %0d cycles: %0d mismatches, %0d bus errors",
			consumed, jump_count, cyc, mismatch_count, bus_error_count);
		if (mismatch_count == 0 && bus_error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// stops a run in which decode starves
	initial begin
		while (cyc < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		$display("timeout: the front end hung after %0d cycles with %0d of %0d instructions",
			cyc, consumed, N_INSTR);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/fetch_pkg.sv
rtl/fetch_data_if.sv
rtl/queue_head_if.sv
rtl/fetch_request_gen.sv
rtl/prefetch_queue.sv
rtl/instr_aligner.sv
rtl/fetch_frontend.sv
verification/tb_fetch_frontend.sv
